// File: source/mipsPkg.sv
`default_nettype none

package mipsPkg;

    // Machine word and register width
    localparam int DATA_WIDTH = 32;

    //////////////////////////////
    // Instruction encodings
    //////////////////////////////

    typedef enum logic [5:0]
    {
        OP_RTYPE = 6'b000000,
        OP_BEQ   = 6'b000100,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcodeE;

    // Funct field of the R-type group
    typedef enum logic [5:0]
    {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_SLT = 6'b101010
    } functE;

    //////////////////////////////
    // Datapath control
    //////////////////////////////

    // Class driven by the decoder and refined by funct in the ALU
    typedef enum logic [1:0]
    {
        ALU_ADD_CLASS   = 2'b00,
        ALU_SUB_CLASS   = 2'b01,
        ALU_FUNCT_CLASS = 2'b10
    } aluClassE;

    typedef enum logic [2:0]
    {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        SLT = 3'd4
    } aluOpE;

    typedef enum logic [1:0]
    {
        S_FETCH = 2'd0,
        S_EXEC  = 2'd1,
        S_MEM   = 2'd2
    } seqStateE;

endpackage

`default_nettype wire

// File: source/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit
(
    input  wire mipsPkg::aluClassE           i_aluClass,
    input  wire  [5:0]                       i_funct,
    input  wire  [mipsPkg::DATA_WIDTH-1:0]   i_opA,
    input  wire  [mipsPkg::DATA_WIDTH-1:0]   i_opB,
    output logic [mipsPkg::DATA_WIDTH-1:0]   o_result,
    output logic                             o_zero
);

    mipsPkg::aluOpE aluOp;
    logic           opValid;

    //////////////////////////////
    // ALU control
    //////////////////////////////

    always_comb
    begin
        aluOp   = mipsPkg::ADD;
        opValid = 1'b1;
        case (i_aluClass)
            mipsPkg::ALU_ADD_CLASS:   aluOp = mipsPkg::ADD;
            mipsPkg::ALU_SUB_CLASS:   aluOp = mipsPkg::SUB;
            mipsPkg::ALU_FUNCT_CLASS:
            begin
                case (i_funct)
                    mipsPkg::FN_ADD: aluOp = mipsPkg::ADD;
                    mipsPkg::FN_SUB: aluOp = mipsPkg::SUB;
                    mipsPkg::FN_AND: aluOp = mipsPkg::AND;
                    mipsPkg::FN_OR:  aluOp = mipsPkg::OR;
                    mipsPkg::FN_SLT: aluOp = mipsPkg::SLT;
                    default:         opValid = 1'b0;
                endcase
            end
            default:                  opValid = 1'b0;
        endcase
    end

    //////////////////////////////
    // Compute
    //////////////////////////////

    always_comb
    begin
        case (aluOp)
            mipsPkg::ADD: o_result = i_opA + i_opB;
            mipsPkg::SUB: o_result = i_opA - i_opB;
            mipsPkg::AND: o_result = i_opA & i_opB;
            mipsPkg::OR:  o_result = i_opA | i_opB;
            // signed compare
            mipsPkg::SLT: o_result = {{(mipsPkg::DATA_WIDTH-1){1'b0}},
                                      ($signed(i_opA) < $signed(i_opB))};
            default:      o_result = '0;
        endcase
        if (!opValid)
            o_result = '0;
    end

    assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

// File: source/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit
(
    input  wire  [5:0]              i_opcode,
    output logic                    o_regDst,
    output logic                    o_branch,
    output logic                    o_memRead,
    output logic                    o_memToReg,
    output mipsPkg::aluClassE       o_aluClass,
    output logic                    o_memWrite,
    output logic                    o_aluSrc,
    output logic                    o_regWrite
);

    always_comb
    begin
        // Unknown opcodes fall through as no-ops
        o_regDst   = 1'b0;
        o_branch   = 1'b0;
        o_memRead  = 1'b0;
        o_memToReg = 1'b0;
        o_aluClass = mipsPkg::ALU_ADD_CLASS;
        o_memWrite = 1'b0;
        o_aluSrc   = 1'b0;
        o_regWrite = 1'b0;

        case (i_opcode)
            mipsPkg::OP_RTYPE:
            begin
                o_regDst   = 1'b1;
                o_aluClass = mipsPkg::ALU_FUNCT_CLASS;
                o_regWrite = 1'b1;
            end

            mipsPkg::OP_LW:
            begin
                o_memRead  = 1'b1;
                o_memToReg = 1'b1;
                o_aluSrc   = 1'b1;
                o_regWrite = 1'b1;
            end

            mipsPkg::OP_SW:
            begin
                o_memWrite = 1'b1;
                o_aluSrc   = 1'b1;
            end

            mipsPkg::OP_BEQ:
            begin
                o_branch   = 1'b1;
                o_aluClass = mipsPkg::ALU_SUB_CLASS;
            end

            default:
            begin
                o_regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/coreSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module coreSequencer
(
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  wire                 i_instrValid,
    input  wire                 i_branch,
    input  wire                 i_zero,
    input  wire                 i_memRead,
    input  wire                 i_memWrite,
    input  wire                 i_lsDone,
    output logic                o_take,
    output logic                o_lsStart,
    output logic                o_redirect,
    output mipsPkg::seqStateE   o_state
);

    mipsPkg::seqStateE state;
    mipsPkg::seqStateE stateNext;

    always_comb
    begin
        stateNext  = state;
        o_take     = 1'b0;
        o_lsStart  = 1'b0;
        o_redirect = 1'b0;

        case (state)
            mipsPkg::S_FETCH:
            begin
                if (i_instrValid)
                begin
                    o_take    = 1'b1;
                    stateNext = mipsPkg::S_EXEC;
                end
            end

            mipsPkg::S_EXEC:
            begin
                o_redirect = i_branch && i_zero;
                if (i_memRead || i_memWrite)
                begin
                    o_lsStart = 1'b1;
                    stateNext = mipsPkg::S_MEM;
                end
                else
                begin
                    stateNext = mipsPkg::S_FETCH;
                end
            end

            // Held here until the load/store unit reports back
            mipsPkg::S_MEM:
            begin
                if (i_lsDone)
                    stateNext = mipsPkg::S_FETCH;
            end

            default:
            begin
                stateNext = mipsPkg::S_FETCH;
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            state <= mipsPkg::S_FETCH;
        else
            state <= stateNext;
    end

    assign o_state = state;

endmodule

`default_nettype wire

// File: source/fetchUnit.sv
`timescale 1ns/10ps
`default_nettype none

module fetchUnit
#(
    parameter int                    ADDR_WIDTH = 10,
    parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
)
(
    input  wire                              i_clk,
    input  wire                              i_rst,
    input  wire                              i_take,
    input  wire                              i_redirect,
    input  wire  [ADDR_WIDTH-1:0]            i_target,
    output logic                             o_instrValid,
    output logic [mipsPkg::DATA_WIDTH-1:0]   o_instr,
    output logic [ADDR_WIDTH-1:0]            o_pc,
    output logic                             o_fetchReq,
    output logic [ADDR_WIDTH-1:0]            o_fetchAddr,
    input  wire                              i_fetchAck,
    input  wire  [mipsPkg::DATA_WIDTH-1:0]   i_fetchData
);

    logic                             reqActive;
    logic                             discard;
    logic                             startReq;
    logic [ADDR_WIDTH-1:0]            startPc;
    logic [ADDR_WIDTH-1:0]            nextPc;
    logic [ADDR_WIDTH-1:0]            reqPc;
    logic                             bufValid;
    logic [mipsPkg::DATA_WIDTH-1:0]   bufInstr;
    logic [ADDR_WIDTH-1:0]            bufPc;

    // New fetch once the buffer is free and nothing is in flight
    assign startReq = !reqActive && (!bufValid || i_take || i_redirect);
    assign startPc  = i_redirect ? i_target : nextPc;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            reqActive <= 1'b0;
            discard   <= 1'b0;
            bufValid  <= 1'b0;
            nextPc    <= RESET_PC;
        end
        else
        begin
            if (i_fetchAck)
            begin
                reqActive <= 1'b0;
                discard   <= 1'b0;
            end
            if (startReq)
            begin
                reqActive <= 1'b1;
                nextPc    <= startPc + ADDR_WIDTH'(4);
            end
            else if (i_redirect)
            begin
                // Old-path fetch still pending so its word is dropped later
                nextPc  <= i_target;
                discard <= !i_fetchAck;
            end

            if (i_take || i_redirect)
                bufValid <= 1'b0;
            if (i_fetchAck && !discard && !i_redirect)
                bufValid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (startReq)
            reqPc <= startPc;
        if (i_fetchAck)
        begin
            bufInstr <= i_fetchData;
            bufPc    <= reqPc;
        end
        // Instruction register for the sequencer
        if (i_take)
        begin
            o_instr <= bufInstr;
            o_pc    <= bufPc;
        end
    end

    assign o_instrValid = bufValid;
    assign o_fetchReq   = reqActive;
    assign o_fetchAddr  = reqPc;

endmodule

`default_nettype wire

// File: source/loadStoreUnit.sv
`timescale 1ns/10ps
`default_nettype none

module loadStoreUnit
#(
    parameter int ADDR_WIDTH = 10
)
(
    input  wire                              i_clk,
    input  wire                              i_rst,
    input  wire                              i_start,
    input  wire                              i_write,
    input  wire  [ADDR_WIDTH-1:0]            i_addr,
    input  wire  [mipsPkg::DATA_WIDTH-1:0]   i_wData,
    output logic                             o_lsReq,
    output logic                             o_lsWe,
    output logic [ADDR_WIDTH-1:0]            o_lsAddr,
    output logic [mipsPkg::DATA_WIDTH-1:0]   o_lsWData,
    input  wire                              i_lsAck,
    input  wire  [mipsPkg::DATA_WIDTH-1:0]   i_lsRData,
    output logic                             o_lsDone,
    output logic [mipsPkg::DATA_WIDTH-1:0]   o_loadData
);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_lsReq  <= 1'b0;
            o_lsWe   <= 1'b0;
            o_lsDone <= 1'b0;
        end
        else
        begin
            // Done one cycle after the acknowledge
            o_lsDone <= i_lsAck;
            if (i_start)
            begin
                o_lsReq <= 1'b1;
                o_lsWe  <= i_write;
            end
            else if (i_lsAck)
            begin
                o_lsReq <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            o_lsAddr  <= i_addr;
            o_lsWData <= i_wData;
        end
        if (i_lsAck)
            o_loadData <= i_lsRData;
    end

endmodule

`default_nettype wire

// File: source/memArbiter.sv
`timescale 1ns/10ps
`default_nettype none

module memArbiter
#(
    parameter int ADDR_WIDTH = 10
)
(
    input  wire                              i_clk,
    input  wire                              i_rst,
    // Fetch peer
    input  wire                              i_fetchReq,
    input  wire  [ADDR_WIDTH-1:0]            i_fetchAddr,
    output logic                             o_fetchAck,
    output logic [mipsPkg::DATA_WIDTH-1:0]   o_fetchRData,
    // Load/store peer
    input  wire                              i_lsReq,
    input  wire                              i_lsWe,
    input  wire  [ADDR_WIDTH-1:0]            i_lsAddr,
    input  wire  [mipsPkg::DATA_WIDTH-1:0]   i_lsWData,
    output logic                             o_lsAck,
    output logic [mipsPkg::DATA_WIDTH-1:0]   o_lsRData,
    // External memory
    output logic                             o_memReq,
    output logic                             o_memWe,
    output logic [ADDR_WIDTH-1:0]            o_memAddr,
    output logic [mipsPkg::DATA_WIDTH-1:0]   o_memWData,
    input  wire                              i_memAck,
    input  wire  [mipsPkg::DATA_WIDTH-1:0]   i_memRData
);

    logic busy;
    logic ownerLs;
    logic grantLs;

    // Idle port goes to load/store first and a busy port stays with its owner
    assign grantLs = busy ? ownerLs : i_lsReq;

    assign o_memReq   = grantLs ? i_lsReq : i_fetchReq;
    assign o_memWe    = grantLs && i_lsWe;
    assign o_memAddr  = grantLs ? i_lsAddr : i_fetchAddr;
    assign o_memWData = i_lsWData;

    assign o_lsAck      = i_memAck && grantLs;
    assign o_fetchAck   = i_memAck && !grantLs;
    assign o_lsRData    = i_memRData;
    assign o_fetchRData = i_memRData;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            busy    <= 1'b0;
            ownerLs <= 1'b0;
        end
        else if (i_memAck)
        begin
            busy <= 1'b0;
        end
        else if (!busy && o_memReq)
        begin
            busy    <= 1'b1;
            ownerLs <= grantLs;
        end
    end

endmodule

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile
(
    input  wire                              i_clk,
    input  wire                              i_rst,
    input  wire  [4:0]                       i_rdAddrA,
    input  wire  [4:0]                       i_rdAddrB,
    output logic [mipsPkg::DATA_WIDTH-1:0]   o_rdDataA,
    output logic [mipsPkg::DATA_WIDTH-1:0]   o_rdDataB,
    input  wire                              i_we,
    input  wire  [4:0]                       i_wrAddr,
    input  wire  [mipsPkg::DATA_WIDTH-1:0]   i_wrData
);

    logic [mipsPkg::DATA_WIDTH-1:0] regs [32];

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        // r0 is never written so it reads as zero
        else if (i_we && (i_wrAddr != 5'd0))
        begin
            regs[i_wrAddr] <= i_wrData;
        end
    end

    assign o_rdDataA = regs[i_rdAddrA];
    assign o_rdDataB = regs[i_rdAddrB];

endmodule

`default_nettype wire

// File: source/mipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module mipsCore
#(
    parameter int                    ADDR_WIDTH = 10,
    parameter logic [ADDR_WIDTH-1:0] RESET_PC   = '0
)
(
    input  wire                                 i_clk,
    input  wire                                 i_rst,
    output logic                                o_memReq,
    output logic                                o_memWe,
    output logic [ADDR_WIDTH-1:0]               o_memAddr,
    output logic [mipsPkg::DATA_WIDTH-1:0]      o_memWData,
    input  wire                                 i_memAck,
    input  wire  [mipsPkg::DATA_WIDTH-1:0]      i_memRData
);

    localparam int DW = mipsPkg::DATA_WIDTH;

    // Fetch side
    logic                  instrValid;
    logic [DW-1:0]         instr;
    logic [ADDR_WIDTH-1:0] pc;
    logic                  take;
    logic                  redirect;
    logic                  fetchReq;
    logic [ADDR_WIDTH-1:0] fetchAddr;
    logic                  fetchAck;
    logic [DW-1:0]         fetchRData;

    // Decoded controls
    logic                  regDst;
    logic                  branch;
    logic                  memRead;
    logic                  memToReg;
    mipsPkg::aluClassE     aluClass;
    logic                  memWrite;
    logic                  aluSrc;
    logic                  regWrite;
    mipsPkg::seqStateE     state;

    // Datapath
    logic [DW-1:0]         rdDataA;
    logic [DW-1:0]         rdDataB;
    logic [4:0]            wrAddr;
    logic [DW-1:0]         wrData;
    logic                  regWe;
    logic [DW-1:0]         signExt;
    logic [DW-1:0]         aluOpB;
    logic [DW-1:0]         aluResult;
    logic                  zero;
    logic [DW-1:0]         pcPlus4;
    logic [DW-1:0]         branchTarget;

    // Load/store side
    logic                  lsStart;
    logic                  lsDone;
    logic                  lsReq;
    logic                  lsWe;
    logic [ADDR_WIDTH-1:0] lsAddr;
    logic [DW-1:0]         lsWData;
    logic                  lsAck;
    logic [DW-1:0]         lsRData;
    logic [DW-1:0]         loadData;

    //////////////////////////////
    // Glue
    //////////////////////////////

    assign signExt      = {{(DW-16){instr[15]}}, instr[15:0]};
    assign pcPlus4      = {{(DW-ADDR_WIDTH){1'b0}}, pc} + DW'(4);
    assign branchTarget = pcPlus4 + {signExt[DW-3:0], 2'b00};

    // Offset operand for LW and SW and register rt otherwise
    assign aluOpB = aluSrc ? signExt : rdDataB;

    // R-type writes in S_EXEC and LW when the load word arrives
    assign wrAddr = regDst ? instr[15:11] : instr[20:16];
    assign wrData = memToReg ? loadData : aluResult;
    assign regWe  = regWrite && (memToReg ? lsDone : (state == mipsPkg::S_EXEC));

    fetchUnit
    #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .RESET_PC   (RESET_PC)
    )
    u_fetch
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_take       (take),
        .i_redirect   (redirect),
        .i_target     (branchTarget[ADDR_WIDTH-1:0]),
        .o_instrValid (instrValid),
        .o_instr      (instr),
        .o_pc         (pc),
        .o_fetchReq   (fetchReq),
        .o_fetchAddr  (fetchAddr),
        .i_fetchAck   (fetchAck),
        .i_fetchData  (fetchRData)
    );

    controlUnit u_control
    (
        .i_opcode   (instr[31:26]),
        .o_regDst   (regDst),
        .o_branch   (branch),
        .o_memRead  (memRead),
        .o_memToReg (memToReg),
        .o_aluClass (aluClass),
        .o_memWrite (memWrite),
        .o_aluSrc   (aluSrc),
        .o_regWrite (regWrite)
    );

    coreSequencer u_seq
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_instrValid (instrValid),
        .i_branch     (branch),
        .i_zero       (zero),
        .i_memRead    (memRead),
        .i_memWrite   (memWrite),
        .i_lsDone     (lsDone),
        .o_take       (take),
        .o_lsStart    (lsStart),
        .o_redirect   (redirect),
        .o_state      (state)
    );

    regFile u_regs
    (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rdAddrA (instr[25:21]),
        .i_rdAddrB (instr[20:16]),
        .o_rdDataA (rdDataA),
        .o_rdDataB (rdDataB),
        .i_we      (regWe),
        .i_wrAddr  (wrAddr),
        .i_wrData  (wrData)
    );

    aluUnit u_alu
    (
        .i_aluClass (aluClass),
        .i_funct    (instr[5:0]),
        .i_opA      (rdDataA),
        .i_opB      (aluOpB),
        .o_result   (aluResult),
        .o_zero     (zero)
    );

    loadStoreUnit #(.ADDR_WIDTH(ADDR_WIDTH)) u_ls
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_start    (lsStart),
        .i_write    (memWrite),
        .i_addr     (aluResult[ADDR_WIDTH-1:0]),
        .i_wData    (rdDataB),
        .o_lsReq    (lsReq),
        .o_lsWe     (lsWe),
        .o_lsAddr   (lsAddr),
        .o_lsWData  (lsWData),
        .i_lsAck    (lsAck),
        .i_lsRData  (lsRData),
        .o_lsDone   (lsDone),
        .o_loadData (loadData)
    );

    memArbiter #(.ADDR_WIDTH(ADDR_WIDTH)) u_arb
    (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_fetchReq   (fetchReq),
        .i_fetchAddr  (fetchAddr),
        .o_fetchAck   (fetchAck),
        .o_fetchRData (fetchRData),
        .i_lsReq      (lsReq),
        .i_lsWe       (lsWe),
        .i_lsAddr     (lsAddr),
        .i_lsWData    (lsWData),
        .o_lsAck      (lsAck),
        .o_lsRData    (lsRData),
        .o_memReq     (o_memReq),
        .o_memWe      (o_memWe),
        .o_memAddr    (o_memAddr),
        .o_memWData   (o_memWData),
        .i_memAck     (i_memAck),
        .i_memRData   (i_memRData)
    );

endmodule

`default_nettype wire

// File: test/mipsModel.sv
`default_nettype none

package mipsModel;

    localparam int MEM_WORDS  = 256;
    localparam int STEP_LIMIT = 4000;

    // R-type result straight from the funct field
    function automatic logic [31:0] applyFunct(
        input logic [5:0]  funct,
        input logic [31:0] a,
        input logic [31:0] b
    );
        mipsPkg::aluOpE op;
        logic           known;
        known = 1'b1;
        op    = mipsPkg::ADD;
        case (funct)
            mipsPkg::FN_ADD: op = mipsPkg::ADD;
            mipsPkg::FN_SUB: op = mipsPkg::SUB;
            mipsPkg::FN_AND: op = mipsPkg::AND;
            mipsPkg::FN_OR:  op = mipsPkg::OR;
            mipsPkg::FN_SLT: op = mipsPkg::SLT;
            default:         known = 1'b0;
        endcase
        if (!known)
            return '0;
        case (op)
            mipsPkg::ADD: return a + b;
            mipsPkg::SUB: return a - b;
            mipsPkg::AND: return a & b;
            mipsPkg::OR:  return a | b;
            mipsPkg::SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:      return '0;
        endcase
    endfunction

    //////////////////////////////
    // Instruction-level run
    //////////////////////////////

    // Returns 1 once the BEQ self-loop is reached
    function automatic bit runProgram(
        ref logic [31:0] image [MEM_WORDS],
        ref logic [31:0] storeAddr [$],
        ref logic [31:0] storeData [$],
        ref logic [31:0] regs [32]
    );
        logic [31:0] mem [MEM_WORDS];
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] instr;
        logic [31:0] offset;
        logic [31:0] addr;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        mem = image;
        pc  = '0;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        storeAddr.delete();
        storeData.delete();

        for (int step = 0; step < STEP_LIMIT; step++)
        begin
            instr  = mem[pc[9:2]];
            rs     = instr[25:21];
            rt     = instr[20:16];
            rd     = instr[15:11];
            offset = {{16{instr[15]}}, instr[15:0]};
            addr   = (regs[rs] + offset) & 32'h3FF;
            nextPc = pc + 32'd4;
            case (instr[31:26])
                mipsPkg::OP_RTYPE:
                begin
                    if (rd != 5'd0)
                        regs[rd] = applyFunct(instr[5:0], regs[rs], regs[rt]);
                end
                mipsPkg::OP_LW:
                begin
                    if (rt != 5'd0)
                        regs[rt] = mem[addr[9:2]];
                end
                mipsPkg::OP_SW:
                begin
                    mem[addr[9:2]] = regs[rt];
                    storeAddr.push_back(addr);
                    storeData.push_back(regs[rt]);
                end
                mipsPkg::OP_BEQ:
                begin
                    if (regs[rs] == regs[rt])
                        nextPc = pc + 32'd4 + {offset[29:0], 2'b00};
                    if (nextPc == pc)
                        return 1'b1;
                end
                default:
                begin
                    nextPc = pc + 32'd4;
                end
            endcase
            pc = nextPc & 32'h3FF;
        end
        return 1'b0;
    endfunction

endpackage

`default_nettype wire

// File: test/tbMipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module tbMipsCore;

    localparam int              ADDR_WIDTH = 10;
    localparam logic [9:0]      RESET_PC   = '0;
    localparam int              TIMEOUT    = 2000;

    logic                       i_clk;
    logic                       i_rst;
    logic                       i_memAck;
    logic [31:0]                i_memRData;
    logic                       o_memReq;
    logic                       o_memWe;
    logic [ADDR_WIDTH-1:0]      o_memAddr;
    logic [31:0]                o_memWData;

    logic [31:0]                mem [256];
    logic [31:0]                image [256];
    logic [31:0]                prog [$];
    logic [31:0]                expAddr [$];
    logic [31:0]                expData [$];
    logic [31:0]                expRegs [32];
    int                         storeCount;
    logic                       respEnable;

    mipsCore
    #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .RESET_PC   (RESET_PC)
    )
    u_dut
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .o_memReq   (o_memReq),
        .o_memWe    (o_memWe),
        .o_memAddr  (o_memAddr),
        .o_memWData (o_memWData),
        .i_memAck   (i_memAck),
        .i_memRData (i_memRData)
    );

    always #20 i_clk = ~i_clk;

    task automatic abortRun();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, expected);
            abortRun();
        end
    endtask

    //////////////////////////////
    // Program building
    //////////////////////////////

    function automatic logic [31:0] encodeRType(logic [5:0] funct, int rd, int rs, int rt);
        return {6'(mipsPkg::OP_RTYPE), 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeMemory(logic [5:0] opcode, int rt, logic [15:0] off);
        return {opcode, 5'd0, 5'(rt), off};
    endfunction

    function automatic logic [31:0] encodeBranch(int rs, int rt, logic [15:0] off);
        return {6'(mipsPkg::OP_BEQ), 5'(rs), 5'(rt), off};
    endfunction

    // Word offset somewhere in bytes 512 to 1020
    function automatic logic [15:0] dataOffset();
        return 16'(512 + 4 * $urandom_range(0, 127));
    endfunction

    function automatic logic [31:0] fillWord(int w);
        return {8'(w), ~8'(w), 8'(w) ^ 8'h5A, 8'(w * 3)};
    endfunction

    task automatic buildProgram();
        int          kind;
        int          srcA;
        int          srcB;
        logic [5:0]  fn;
        logic [15:0] off;
        prog.delete();
        // Signed random words from the data area give the registers something to work on
        for (int i = 0; i < 6; i++)
            prog.push_back(encodeMemory(mipsPkg::OP_LW, $urandom_range(1, 15), dataOffset()));
        while (prog.size() < 40)
        begin
            kind = $urandom_range(0, 9);
            srcA = $urandom_range(0, 15);
            srcB = $urandom_range(0, 15);
            if (kind < 5)
            begin
                case ($urandom_range(0, 4))
                    0:       fn = mipsPkg::FN_ADD;
                    1:       fn = mipsPkg::FN_SUB;
                    2:       fn = mipsPkg::FN_AND;
                    3:       fn = mipsPkg::FN_OR;
                    default: fn = mipsPkg::FN_SLT;
                endcase
                // r0 is sometimes the destination and must stay zero
                prog.push_back(encodeRType(fn, $urandom_range(0, 15), srcA, srcB));
            end
            else if (kind < 7)
            begin
                prog.push_back(encodeMemory(mipsPkg::OP_SW, srcA, dataOffset()));
            end
            else if (kind < 8)
            begin
                off = dataOffset();
                prog.push_back(encodeMemory(mipsPkg::OP_SW, srcA, off));
                prog.push_back(encodeMemory(mipsPkg::OP_LW, $urandom_range(1, 15), off));
            end
            else
            begin
                if ($urandom_range(0, 1) == 1)
                    srcB = srcA;
                prog.push_back(encodeBranch(srcA, srcB, 16'($urandom_range(1, 3))));
            end
        end
        for (int r = 1; r < 16; r++)
            prog.push_back(encodeMemory(mipsPkg::OP_SW, r, 16'(512 + 4 * (r - 1))));
        prog.push_back(encodeBranch(0, 0, 16'hFFFF));
    endtask

    task automatic recordStore(input logic [31:0] addr, input logic [31:0] data);
        if (storeCount >= expAddr.size())
        begin
            $display("A store appeared after the whole expected store list was seen");
            abortRun();
        end
        checkValue("store address", addr, expAddr[storeCount]);
        checkValue("store data", data, expData[storeCount]);
        storeCount++;
    endtask

    //////////////////////////////
    // Memory responder
    //////////////////////////////

    initial
    begin : responder
        int          delay;
        int          waited;
        logic        active;
        logic [9:0]  holdAddr;
        logic        holdWe;
        logic [31:0] holdData;
        i_memAck   = 1'b0;
        i_memRData = '0;
        active     = 1'b0;
        delay      = 0;
        waited     = 0;
        holdAddr   = '0;
        holdWe     = 1'b0;
        holdData   = '0;
        forever
        begin
            @(posedge i_clk);
            #2;
            i_memAck = 1'b0;
            if (respEnable && o_memReq)
            begin
                if (!active)
                begin
                    active   = 1'b1;
                    delay    = $urandom_range(1, 6);
                    waited   = 0;
                    holdAddr = o_memAddr;
                    holdWe   = o_memWe;
                    holdData = o_memWData;
                end
                else
                begin
                    // Waiting request must not move
                    checkValue("o_memAddr", o_memAddr, holdAddr);
                    checkValue("o_memWe", o_memWe, holdWe);
                    if (holdWe)
                        checkValue("o_memWData", o_memWData, holdData);
                end
                waited++;
                if (waited == delay)
                begin
                    i_memAck = 1'b1;
                    active   = 1'b0;
                    if (o_memWe)
                    begin
                        mem[o_memAddr[9:2]] = o_memWData;
                        recordStore({22'd0, o_memAddr}, o_memWData);
                    end
                    else
                    begin
                        i_memRData = mem[o_memAddr[9:2]];
                    end
                end
            end
            else if (respEnable && active)
            begin
                $display("o_memReq dropped at %0t before its acknowledge", $time);
                abortRun();
            end
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin : mainFlow
        int cycles;
        int lastCount;
        i_clk      = 1'b0;
        i_rst      = 1'b1;
        respEnable = 1'b0;
        storeCount = 0;
        void'($urandom(32'h58bd_925c));

        buildProgram();
        for (int w = 0; w < 256; w++)
            mem[w] = fillWord(w);
        for (int w = 128; w < 256; w++)
            mem[w] = $urandom();
        foreach (prog[i])
            mem[i] = prog[i];
        image = mem;
        if (!mipsModel::runProgram(image, expAddr, expData, expRegs))
        begin
            $display("The reference model never reached the final branch loop");
            abortRun();
        end

        @(posedge i_clk);
        #2;
        checkValue("o_memReq", o_memReq, 1'b0);
        checkValue("o_memWe", o_memWe, 1'b0);
        @(posedge i_clk);
        #2;
        i_rst = 1'b0;

        // Acknowledge held off so only the reset fetch may show up
        for (int i = 0; i < 6; i++)
        begin
            @(posedge i_clk);
            #2;
            if (o_memReq)
                checkValue("o_memAddr", o_memAddr, RESET_PC);
            checkValue("o_memWe", o_memWe, 1'b0);
        end
        checkValue("o_memReq", o_memReq, 1'b1);
        @(negedge i_clk);
        respEnable = 1'b1;

        while (storeCount < expAddr.size())
        begin
            lastCount = storeCount;
            cycles    = 0;
            while (storeCount == lastCount && cycles < TIMEOUT)
            begin
                @(posedge i_clk);
                cycles++;
            end
            if (storeCount == lastCount)
            begin
                $display("Store %0d of %0d never reached the memory port",
                         lastCount + 1, expAddr.size());
                abortRun();
            end
        end

        // Quiet stretch in which no further store may appear
        repeat (20) @(posedge i_clk);
        #2;
        for (int r = 0; r < 32; r++)
            checkValue($sformatf("u_regs.regs[%0d]", r), u_dut.u_regs.regs[r], expRegs[r]);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
source/mipsPkg.sv
source/aluUnit.sv
source/controlUnit.sv
source/coreSequencer.sv
source/fetchUnit.sv
source/loadStoreUnit.sv
source/memArbiter.sv
source/regFile.sv
source/mipsCore.sv
test/mipsModel.sv
test/tbMipsCore.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - source/mipsPkg.sv
  - source/aluUnit.sv
  - source/controlUnit.sv
  - source/coreSequencer.sv
  - source/fetchUnit.sv
  - source/loadStoreUnit.sv
  - source/memArbiter.sv
  - source/regFile.sv
  - source/mipsCore.sv
  - target: test
    files:
      - test/mipsModel.sv
      - test/tbMipsCore.sv
